// ==== rtl/tracker_consts.svh ====
`ifndef TRACKER_CONSTS_SVH
`define TRACKER_CONSTS_SVH

// Frame geometry, pixels per row and rows per frame
`define FRAME_WIDTH     320
`define FRAME_HEIGHT    240

// Field widths
`define CHAN_W          4       // One RGB444 channel
`define EDGE_W          9       // Band edge, holds any column of a 320 wide row
`define DETECT_W        18      // Detection minimum
`define COUNT_W         18      // Orange count result
`define REG_DATA_W      18      // Register port data

// Register reset values
`define DEF_RED_MIN     10
`define DEF_GREEN_MIN   3
`define DEF_GREEN_MAX   9
`define DEF_BLUE_MAX    4
`define DEF_LEFT_EDGE   70      // Left band is columns 0..69
`define DEF_RIGHT_EDGE  290     // Right band starts at column 290
`define DEF_DETECT_MIN  768     // About 1% of a full frame

`endif

// ==== rtl/tracker_pkg.sv ====
`include "tracker_consts.svh"

package tracker_pkg;

    // One RGB444 pixel, red in the top nibble
    typedef struct packed {
        logic [`CHAN_W-1:0] red;
        logic [`CHAN_W-1:0] green;
        logic [`CHAN_W-1:0] blue;
    } pixel_t;

    // Orange colour window
    typedef struct packed {
        logic [`CHAN_W-1:0] red_min;
        logic [`CHAN_W-1:0] green_min;
        logic [`CHAN_W-1:0] green_max;
        logic [`CHAN_W-1:0] blue_max;
    } color_cfg_t;

    // Column band edges and detection minimum
    typedef struct packed {
        logic [`EDGE_W-1:0]   left_edge;
        logic [`EDGE_W-1:0]   right_edge;
        logic [`DETECT_W-1:0] detect_min;
    } region_cfg_t;

    // Steering direction, same codes as the older classifier
    typedef enum logic [2:0] {
        DIR_NONE   = 3'd0,
        DIR_LEFT   = 3'd1,
        DIR_RIGHT  = 3'd2,
        DIR_CENTER = 3'd3
    } direction_e;

    // Per-frame report
    typedef struct packed {
        logic                detected;
        direction_e          direction;
        logic [`COUNT_W-1:0] orange_count;
    } frame_result_t;

    // Configuration register map
    typedef enum logic [2:0] {
        REG_RED_MIN    = 3'd0,
        REG_GREEN_MIN  = 3'd1,
        REG_GREEN_MAX  = 3'd2,
        REG_BLUE_MAX   = 3'd3,
        REG_LEFT_EDGE  = 3'd4,
        REG_RIGHT_EDGE = 3'd5,
        REG_DETECT_MIN = 3'd6
    } reg_addr_e;

endpackage

// ==== rtl/color_threshold.sv ====
`timescale 1ns/100ps

module color_threshold import tracker_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  pixel_t     pixel,        // Incoming RGB444 pixel
    input  logic       active_area,  // High over the visible part of a row
    input  color_cfg_t color_cfg,    // Programmed colour window
    output logic       is_orange,    // Registered orange decision
    output logic       active_d      // active_area one cycle late, aligned with is_orange
);

    logic red_ok;
    logic green_ok;
    logic blue_ok;
    logic in_window;

    // Red has only a floor, orange is strong in red
    assign red_ok = (pixel.red >= color_cfg.red_min);

    // Green must sit inside a band, too little is red, too much is yellow
    assign green_ok = (pixel.green >= color_cfg.green_min) &&
                      (pixel.green <= color_cfg.green_max);

    assign blue_ok = (pixel.blue <= color_cfg.blue_max);  // Blue only has a ceiling

    assign in_window = red_ok && green_ok && blue_ok;

    // One cycle of latency for both outputs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            is_orange <= 1'b0;
            active_d  <= 1'b0;
        end else begin
            is_orange <= active_area && in_window;  // Blanking data never counts
            active_d  <= active_area;
        end
    end

endmodule

// ==== rtl/region_classifier.sv ====
`timescale 1ns/100ps
`include "tracker_consts.svh"

module region_classifier import tracker_pkg::*; #(
    parameter int FRAME_WIDTH  = 320,  // Active pixels per row
    parameter int FRAME_HEIGHT = 240   // Rows per frame
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          is_orange,   // Orange decision for the current pixel
    input  logic          active_d,    // Valid pixel this cycle
    input  region_cfg_t   region_cfg,  // Band edges and detection minimum
    output frame_result_t result,      // Held until the next frame ends
    output logic          frame_done   // One cycle pulse when result updates
);

    localparam int COL_W = $clog2(FRAME_WIDTH);
    localparam int ROW_W = $clog2(FRAME_HEIGHT);
    localparam int CNT_W = $clog2(FRAME_WIDTH * FRAME_HEIGHT + 1);  // Holds a full frame

    logic [COL_W-1:0] col;          // Column within the row
    logic [ROW_W-1:0] row;          // Row within the frame
    logic [CNT_W-1:0] left_cnt;
    logic [CNT_W-1:0] center_cnt;
    logic [CNT_W-1:0] right_cnt;
    logic [CNT_W-1:0] total_cnt;

    // Counter values including the pixel of this cycle
    logic [CNT_W-1:0] left_next;
    logic [CNT_W-1:0] center_next;
    logic [CNT_W-1:0] right_next;
    logic [CNT_W-1:0] total_next;

    logic       in_left;
    logic       in_center;
    logic       count_px;
    logic       row_end;
    logic       frame_end;
    logic       detect_next;
    direction_e dir_next;

    // Band select by column, left wins over center
    assign in_left   = (32'(col) < 32'(region_cfg.left_edge));
    assign in_center = !in_left && (32'(col) < 32'(region_cfg.right_edge));

    assign count_px = active_d && is_orange;

    assign left_next   = left_cnt + CNT_W'(count_px && in_left);
    assign center_next = center_cnt + CNT_W'(count_px && in_center);
    assign right_next  = right_cnt + CNT_W'(count_px && !in_left && !in_center);
    assign total_next  = total_cnt + CNT_W'(count_px);

    // Last pixel of a row, and of the last row
    assign row_end   = active_d && (col == COL_W'(FRAME_WIDTH - 1));
    assign frame_end = row_end && (row == ROW_W'(FRAME_HEIGHT - 1));

    assign detect_next = (32'(total_next) > 32'(region_cfg.detect_min));  // Strictly more

    // Steering priority is right, then center, then left
    always_comb begin
        dir_next = result.direction;  // Ties and misses keep the old heading
        if (detect_next) begin
            if (right_next > left_next) begin
                dir_next = DIR_RIGHT;
            end else if ((center_next > right_next) && (center_next > left_next)) begin
                dir_next = DIR_CENTER;
            end else if (left_next > right_next) begin
                dir_next = DIR_LEFT;
            end
        end
    end

    // Column and row position
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else begin
            if (!active_d || row_end) begin
                col <= '0;  // Back to column 0 in blanking or after the last column
            end else begin
                col <= col + 1'b1;
            end
            if (frame_end) begin
                row <= '0;
            end else if (row_end) begin
                row <= row + 1'b1;
            end
        end
    end

    // Orange counters, cleared once the frame is reported
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            left_cnt   <= '0;
            center_cnt <= '0;
            right_cnt  <= '0;
            total_cnt  <= '0;
        end else if (frame_end) begin
            left_cnt   <= '0;
            center_cnt <= '0;
            right_cnt  <= '0;
            total_cnt  <= '0;
        end else begin
            left_cnt   <= left_next;
            center_cnt <= center_next;
            right_cnt  <= right_next;
            total_cnt  <= total_next;
        end
    end

    // Frame report
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result     <= '{detected: 1'b0, direction: DIR_NONE, orange_count: '0};
            frame_done <= 1'b0;
        end else begin
            frame_done <= frame_end;
            if (frame_end) begin
                result.detected     <= detect_next;
                result.direction    <= dir_next;
                result.orange_count <= `COUNT_W'(total_next);  // Reported even when not detected
            end
        end
    end

endmodule

// ==== rtl/tracker_regs.sv ====
`timescale 1ns/100ps
`include "tracker_consts.svh"

module tracker_regs import tracker_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   reg_we,      // Write strobe, one cycle
    input  reg_addr_e              reg_addr,    // Selects the field for write and read
    input  logic [`REG_DATA_W-1:0] reg_wdata,
    output logic [`REG_DATA_W-1:0] reg_rdata,   // Selected field, zero extended
    output color_cfg_t             color_cfg,
    output region_cfg_t            region_cfg
);

    // Colour window
    logic [`CHAN_W-1:0]   red_min;
    logic [`CHAN_W-1:0]   green_min;
    logic [`CHAN_W-1:0]   green_max;
    logic [`CHAN_W-1:0]   blue_max;

    // Band edges and detection minimum
    logic [`EDGE_W-1:0]   left_edge;
    logic [`EDGE_W-1:0]   right_edge;
    logic [`DETECT_W-1:0] detect_min;

    // Write side, only the low bits that fit the field are kept
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red_min    <= `CHAN_W'(`DEF_RED_MIN);
            green_min  <= `CHAN_W'(`DEF_GREEN_MIN);
            green_max  <= `CHAN_W'(`DEF_GREEN_MAX);
            blue_max   <= `CHAN_W'(`DEF_BLUE_MAX);
            left_edge  <= `EDGE_W'(`DEF_LEFT_EDGE);
            right_edge <= `EDGE_W'(`DEF_RIGHT_EDGE);
            detect_min <= `DETECT_W'(`DEF_DETECT_MIN);
        end else if (reg_we) begin
            case (reg_addr)
                REG_RED_MIN:    red_min    <= reg_wdata[`CHAN_W-1:0];
                REG_GREEN_MIN:  green_min  <= reg_wdata[`CHAN_W-1:0];
                REG_GREEN_MAX:  green_max  <= reg_wdata[`CHAN_W-1:0];
                REG_BLUE_MAX:   blue_max   <= reg_wdata[`CHAN_W-1:0];
                REG_LEFT_EDGE:  left_edge  <= reg_wdata[`EDGE_W-1:0];
                REG_RIGHT_EDGE: right_edge <= reg_wdata[`EDGE_W-1:0];
                REG_DETECT_MIN: detect_min <= reg_wdata[`DETECT_W-1:0];
                default: ;  // Unmapped address, write is dropped
            endcase
        end
    end

    // Read-back mux
    always_comb begin
        case (reg_addr)
            REG_RED_MIN:    reg_rdata = `REG_DATA_W'(red_min);
            REG_GREEN_MIN:  reg_rdata = `REG_DATA_W'(green_min);
            REG_GREEN_MAX:  reg_rdata = `REG_DATA_W'(green_max);
            REG_BLUE_MAX:   reg_rdata = `REG_DATA_W'(blue_max);
            REG_LEFT_EDGE:  reg_rdata = `REG_DATA_W'(left_edge);
            REG_RIGHT_EDGE: reg_rdata = `REG_DATA_W'(right_edge);
            REG_DETECT_MIN: reg_rdata = `REG_DATA_W'(detect_min);
            default:        reg_rdata = '0;  // Unmapped reads as zero
        endcase
    end

    // Split into the two config groups
    assign color_cfg = '{
        red_min:   red_min,
        green_min: green_min,
        green_max: green_max,
        blue_max:  blue_max
    };

    assign region_cfg = '{
        left_edge:  left_edge,
        right_edge: right_edge,
        detect_min: detect_min
    };

endmodule

// ==== rtl/target_tracker_top.sv ====
`timescale 1ns/100ps
`include "tracker_consts.svh"

module target_tracker_top import tracker_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pixel_t                 pixel,        // Camera pixel, one per clock
    input  logic                   active_area,  // Visible part of the row
    input  logic                   reg_we,
    input  reg_addr_e              reg_addr,
    input  logic [`REG_DATA_W-1:0] reg_wdata,
    output logic [`REG_DATA_W-1:0] reg_rdata,
    output frame_result_t          result,       // Latest frame report
    output logic                   frame_done    // Pulse on each new report
);

    color_cfg_t  color_cfg;
    region_cfg_t region_cfg;
    logic        is_orange;  // From threshold stage, one cycle behind pixel
    logic        active_d;

    // Configuration registers
    tracker_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_we     (reg_we),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .color_cfg  (color_cfg),
        .region_cfg (region_cfg)
    );

    // Per-pixel colour decision
    color_threshold u_threshold (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel       (pixel),
        .active_area (active_area),
        .color_cfg   (color_cfg),
        .is_orange   (is_orange),
        .active_d    (active_d)
    );

    // Band counts and end-of-frame decision
    region_classifier #(
        .FRAME_WIDTH  (`FRAME_WIDTH),
        .FRAME_HEIGHT (`FRAME_HEIGHT)
    ) u_classifier (
        .clk        (clk),
        .rst_n      (rst_n),
        .is_orange  (is_orange),
        .active_d   (active_d),
        .region_cfg (region_cfg),
        .result     (result),
        .frame_done (frame_done)
    );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 40  // Full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;  // First rising edge half a period in
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// ==== bench/target_tracker_asserts.sv ====
`timescale 1ns/100ps

module target_tracker_asserts import tracker_pkg::*; (
    input logic          clk,
    input logic          rst_n,
    input frame_result_t result,
    input logic          frame_done
);

    // One report per frame, never a stretched pulse
    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |=> !frame_done)
        else $error("frame_done high on two cycles in a row");

    // Report is held between frames
    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(result) |-> frame_done)
        else $error("result changed outside a frame_done cycle");

    // Outputs quiet while in reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!frame_done && !result.detected))
        else $error("frame_done or detected high during reset");

endmodule

bind target_tracker_top target_tracker_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .result     (result),
    .frame_done (frame_done)
);

// ==== bench/tb_target_tracker.sv ====
`timescale 1ns/100ps
`include "tracker_consts.svh"

module tb_target_tracker import tracker_pkg::*; ();

    localparam int BLANK_CYCLES = 8;       // Blanking after each row
    localparam int DONE_TIMEOUT = 100000;  // Cycles allowed for frame_done
    localparam int NUM_REGS     = 7;
    localparam int NUM_FIELDS   = 17;      // Columns per scene line

    // One scene from the data file
    typedef struct packed {
        logic [NUM_REGS-1:0][`REG_DATA_W-1:0] regs;  // Indexed by register address
        logic [8:0]          col_lo;
        logic [8:0]          col_hi;
        logic [7:0]          row_lo;
        logic [7:0]          row_hi;
        pixel_t              blob;           // Colour inside the rectangle
        logic                exp_detected;
        direction_e          exp_direction;
        logic [`COUNT_W-1:0] exp_count;
    } scene_t;

    logic                   clk;
    logic                   rst_n;
    pixel_t                 pixel;
    logic                   active_area;
    logic                   reg_we;
    reg_addr_e              reg_addr;
    logic [`REG_DATA_W-1:0] reg_wdata;
    logic [`REG_DATA_W-1:0] reg_rdata;
    frame_result_t          result;
    logic                   frame_done;

    scene_t scenes[$];

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

    target_tracker_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel       (pixel),
        .active_area (active_area),
        .reg_we      (reg_we),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .result      (result),
        .frame_done  (frame_done)
    );

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "%s is wrong", what);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic load_scenes();
        int     fd;
        int     n;
        int     v[NUM_FIELDS];
        string  line;
        scene_t s;
        fd = $fopen("bench/tracker_input.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the scene file bench/tracker_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;  // Blank or comment line
            end
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                        v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
            if (n != NUM_FIELDS) begin
                abort_run({"Scene line has the wrong number of columns: ", line});
            end
            for (int i = 0; i < NUM_REGS; i++) begin
                s.regs[i] = `REG_DATA_W'(v[i]);
            end
            s.col_lo        = 9'(v[7]);
            s.col_hi        = 9'(v[8]);
            s.row_lo        = 8'(v[9]);
            s.row_hi        = 8'(v[10]);
            s.blob.red      = `CHAN_W'(v[11]);
            s.blob.green    = `CHAN_W'(v[12]);
            s.blob.blue     = `CHAN_W'(v[13]);
            s.exp_detected  = 1'(v[14]);
            s.exp_direction = direction_e'(3'(v[15]));
            s.exp_count     = `COUNT_W'(v[16]);
            scenes.push_back(s);
        end
        $fclose(fd);
        if (scenes.size() == 0) begin
            abort_run("The scene file holds no scenes");
        end
    endtask

    // One-cycle write strobe
    task automatic write_reg(input reg_addr_e addr, input logic [`REG_DATA_W-1:0] data);
        @(posedge clk);
        #1;
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_we    = 1'b0;
    endtask

    // Read mux is combinational, sample mid cycle
    task automatic read_check(input reg_addr_e addr, input logic [31:0] expected);
        @(posedge clk);
        #1;
        reg_addr = addr;
        #5;
        check_value($sformatf("read-back of register %0d", addr), 32'(reg_rdata), expected);
    endtask

    function automatic bit in_blob(input scene_t s, input int r, input int c);
        return (r >= int'(s.row_lo)) && (r <= int'(s.row_hi)) &&
               (c >= int'(s.col_lo)) && (c <= int'(s.col_hi));
    endfunction

    // Background pixel that the window rejects
    function automatic pixel_t reject_pixel(input logic [`CHAN_W-1:0] red_min);
        pixel_t p;
        p.red   = `CHAN_W'($urandom % 32'(red_min));  // Always under the red floor
        p.green = `CHAN_W'($urandom);
        p.blue  = `CHAN_W'($urandom);
        return p;
    endfunction

    task automatic run_frame(input scene_t s);
        int cycles;
        for (int r = 0; r < `FRAME_HEIGHT; r++) begin
            for (int c = 0; c < `FRAME_WIDTH; c++) begin
                @(posedge clk);
                #1;
                active_area = 1'b1;
                if (in_blob(s, r, c)) begin
                    pixel = s.blob;
                end else begin
                    pixel = reject_pixel(s.regs[REG_RED_MIN][`CHAN_W-1:0]);
                end
            end
            if (r < `FRAME_HEIGHT - 1) begin
                repeat (BLANK_CYCLES) begin
                    @(posedge clk);
                    #1;
                    active_area = 1'b0;
                    pixel       = '0;
                end
            end
        end
        // Blanking of the last row doubles as the wait for the report
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            active_area = 1'b0;
            pixel       = '0;
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                abort_run("frame_done never came after the last pixel of the frame");
            end
        end while (frame_done !== 1'b1);
        check_value("frame_done latency in cycles", 32'(cycles), 32'd2);  // Two edges
    endtask

    task automatic check_frame(input int idx, input scene_t s, input direction_e prev_dir);
        check_value($sformatf("scene %0d detected", idx),
                    32'(result.detected), 32'(s.exp_detected));
        check_value($sformatf("scene %0d direction", idx),
                    32'(result.direction), 32'(s.exp_direction));
        check_value($sformatf("scene %0d orange count", idx),
                    32'(result.orange_count), 32'(s.exp_count));
        if (!s.exp_detected) begin
            check_value($sformatf("scene %0d held direction", idx),  // Miss keeps heading
                        32'(result.direction), 32'(prev_dir));
        end
    endtask

    initial begin
        direction_e  prev_dir;
        rst_n       = 1'b0;
        pixel       = '0;
        active_area = 1'b0;
        reg_we      = 1'b0;
        reg_addr    = REG_RED_MIN;
        reg_wdata   = '0;
        void'($urandom(40));  // Seed the generator once
        load_scenes();

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state of the report and the registers
        check_value("detected after reset", 32'(result.detected), 32'd0);
        check_value("direction after reset", 32'(result.direction), 32'(DIR_NONE));
        check_value("orange count after reset", 32'(result.orange_count), 32'd0);
        read_check(REG_RED_MIN,    32'(`DEF_RED_MIN));
        read_check(REG_GREEN_MIN,  32'(`DEF_GREEN_MIN));
        read_check(REG_GREEN_MAX,  32'(`DEF_GREEN_MAX));
        read_check(REG_BLUE_MAX,   32'(`DEF_BLUE_MAX));
        read_check(REG_LEFT_EDGE,  32'(`DEF_LEFT_EDGE));
        read_check(REG_RIGHT_EDGE, 32'(`DEF_RIGHT_EDGE));
        read_check(REG_DETECT_MIN, 32'(`DEF_DETECT_MIN));

        prev_dir = DIR_NONE;
        foreach (scenes[i]) begin
            for (int a = 0; a < NUM_REGS; a++) begin
                write_reg(reg_addr_e'(3'(a)), scenes[i].regs[a]);
            end
            for (int a = 0; a < NUM_REGS; a++) begin
                read_check(reg_addr_e'(3'(a)), 32'(scenes[i].regs[a]));
            end
            run_frame(scenes[i]);
            check_frame(i, scenes[i], prev_dir);
            prev_dir = scenes[i].exp_direction;  // Heading the next miss must keep
        end

        $display("test passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/tracker_pkg.sv
rtl/color_threshold.sv
rtl/region_classifier.sv
rtl/tracker_regs.sv
rtl/target_tracker_top.sv
bench/tb_clock.sv
bench/target_tracker_asserts.sv
bench/tb_target_tracker.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_target_tracker

.PHONY: all run clean

all: run

# Simulator binary, rebuilt only when a source or the file list changes
$(SIM): verilog.f $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_target_tracker -f verilog.f

# Pass only when the pass line shows up in the output
run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== bench/tracker_input.txt ====
# red_min green_min green_max blue_max left_edge right_edge detect_min
#   col_lo col_hi row_lo row_hi blob_r blob_g blob_b exp_detected exp_dir exp_count
# Blob rectangle is inclusive; dir codes: 0 none, 1 left, 2 right, 3 center
10 3 9 4 70 290 768 200 209 120 129 12 6 2 0 0 100
10 3 9 4 70 290 768 140 179 100 129 12 6 2 1 3 1200
10 3 9 4 70 290 768 295 319 50 89 12 6 2 1 2 1000
10 3 9 4 70 290 768 0 39 10 39 12 6 2 1 1 1200
10 3 9 4 70 290 768 150 159 0 49 12 6 2 0 1 500
10 3 9 4 70 290 768 100 131 200 223 12 6 2 0 1 768
10 3 9 4 70 290 768 120 159 60 89 10 3 4 1 3 1200
10 3 9 4 70 290 768 120 159 60 89 10 3 5 0 3 0
6 0 15 15 160 200 100 100 149 0 9 7 12 14 1 1 500
6 0 15 15 160 200 99 200 209 230 239 7 12 14 1 2 100
6 0 15 15 150 152 99 140 161 0 9 7 12 14 1 2 220
